/* logic/cache_params.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache geometry and bus widths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// sets per way, power of two.
`define ICACHE_ENTRIES_PER_WAY 64

// two ways, one lru bit per set.
`define ICACHE_WAYS 2

`define MEM_ADDR_W 32 // byte address.
`define MEM_DATA_W 32 // one word per line.

`endif

/* logic/mem_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory request types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "cache_params.svh"

package mem_pkg;

  typedef logic [`MEM_DATA_W-1:0] word_t; // data or address word.

  // byte write mask, zero means read.
  typedef logic [`MEM_DATA_W/8-1:0] wmask_t;

  typedef struct packed {
    word_t  addr;  // byte address.
    word_t  wdata; // store data.
    wmask_t wmask; // byte enables.
  } mem_req_t;

endpackage

`default_nettype wire

/* logic/mem_bus_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid/ready memory bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

interface mem_bus_if;
  import mem_pkg::*;

  mem_req_t req;   // held stable while valid.
  logic     valid; // request pending.
  word_t    rdata; // read data, good while ready.
  logic     ready; // single-cycle completion.

  // side that starts transactions.
  modport requester (
    output req,
    output valid,
    input  rdata,
    input  ready
  );

  // side that completes them.
  modport responder (
    input  req,
    input  valid,
    output rdata,
    output ready
  );

endinterface

`default_nettype wire

/* logic/cache_router.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch/data request router
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module cache_router (
  input  logic            clk,
  input  logic            is_instruction_i, // fetch flag, stable while pending.
  input  mem_pkg::word_t  cpu_addr_i,
  input  mem_pkg::word_t  cpu_din_i,
  input  mem_pkg::wmask_t cpu_wmask_i,
  input  logic            cpu_valid_i,
  output mem_pkg::word_t  cpu_dout_o,
  output logic            cpu_ready_o,
  mem_bus_if.requester    ic_bus,     // lookups into the icache.
  mem_bus_if.responder    refill_bus, // icache refills.
  mem_bus_if.requester    mem_bus     // toward the memory port.
);
  import mem_pkg::*;

  mem_req_t cpu_req;     // data access as issued by the cpu.
  mem_req_t fetch_req;   // refill with the mask cleared.
  logic     mem_valid;   // valid of whichever path owns the port.
  logic     fetch_tag_q; // owner of the outstanding memory access.

  assign cpu_req   = '{addr: cpu_addr_i, wdata: cpu_din_i, wmask: cpu_wmask_i};
  assign fetch_req = '{addr: refill_bus.req.addr, wdata: refill_bus.req.wdata, wmask: '0};

  // fetches never write.
  assign ic_bus.req = '{addr: cpu_addr_i, wdata: cpu_din_i, wmask: '0};

  assign mem_valid = is_instruction_i ? refill_bus.valid : cpu_valid_i;

  // tag the memory access with its path, ready comes at least 2 cycles later.
  always_ff @(posedge clk) begin
    if (mem_valid) begin
      fetch_tag_q <= is_instruction_i; // held with the request.
    end
  end

  always_comb begin
    // data path by default.
    ic_bus.valid     = 1'b0;
    refill_bus.rdata = mem_bus.rdata;        // payload goes to both.
    refill_bus.ready = 1'b0;
    mem_bus.req      = cpu_req;
    mem_bus.valid    = mem_valid;
    cpu_dout_o       = mem_bus.rdata;
    cpu_ready_o      = mem_bus.ready & ~fetch_tag_q;

    if (is_instruction_i) begin
      ic_bus.valid     = cpu_valid_i;         // lookup request.
      refill_bus.ready = mem_bus.ready & fetch_tag_q;
      mem_bus.req      = fetch_req;           // refill owns the port.
      cpu_dout_o       = ic_bus.rdata;
      cpu_ready_o      = ic_bus.ready;
    end
  end

endmodule

`default_nettype wire

/* logic/icache.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2-way set-associative instruction cache
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

`include "cache_params.svh"

module icache #(
  parameter int ENTRIES_PER_WAY = `ICACHE_ENTRIES_PER_WAY // sets, power of two.
) (
  input  logic         clk,
  input  logic         rst_n_i,
  mem_bus_if.responder cpu_bus, // fetch requests.
  mem_bus_if.requester ram_bus  // single-word refills.
);
  import mem_pkg::*;

  localparam int IDX_W = $clog2(ENTRIES_PER_WAY);
  localparam int TAG_W = `MEM_ADDR_W - IDX_W - 2; // word aligned lines.

  typedef enum logic [1:0] {
    IDLE,   // waiting for a fetch.
    LOOKUP, // compare tags of the latched address.
    REFILL  // word read from memory in flight.
  } state_e;

  state_e state_q;
  state_e state_d;

  word_t              addr_q;  // latched fetch address.
  logic [IDX_W-1:0]   idx;     // set index.
  logic [TAG_W-1:0]   tag;     // address tag.

  // line storage, one word per line.
  logic [TAG_W-1:0] tag_q  [`ICACHE_WAYS][ENTRIES_PER_WAY];
  word_t            data_q [`ICACHE_WAYS][ENTRIES_PER_WAY];

  logic [`ICACHE_WAYS-1:0][ENTRIES_PER_WAY-1:0] valid_q; // cleared at reset.
  logic [ENTRIES_PER_WAY-1:0]                   lru_q;   // lru way per set.

  logic hit0;
  logic hit1;
  logic hit;
  logic victim;      // way that takes the refill.
  logic refill_done; // memory returned the word.

  assign idx = addr_q[IDX_W+1:2];
  assign tag = addr_q[`MEM_ADDR_W-1:IDX_W+2];

  assign hit0 = valid_q[0][idx] && (tag_q[0][idx] == tag);
  assign hit1 = valid_q[1][idx] && (tag_q[1][idx] == tag);
  assign hit  = (state_q == LOOKUP) && (hit0 || hit1);

  assign victim      = lru_q[idx];
  assign refill_done = (state_q == REFILL) && ram_bus.ready;

  // answer straight out of the arrays.
  assign cpu_bus.rdata = hit1 ? data_q[1][idx] : data_q[0][idx];
  assign cpu_bus.ready = hit;

  // refill request, reads only.
  assign ram_bus.req.addr  = {addr_q[`MEM_ADDR_W-1:2], 2'b00};
  assign ram_bus.req.wdata = '0;
  assign ram_bus.req.wmask = '0;
  assign ram_bus.valid     = (state_q == REFILL); // registered, cycle after lookup.

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cpu_bus.valid) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit0 || hit1) begin
          state_d = IDLE;   // answered this cycle.
        end else begin
          state_d = REFILL; // miss.
        end
      end
      REFILL: begin
        // a second lookup then hits the new line.
        if (ram_bus.ready) begin
          state_d = LOOKUP;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      valid_q <= '0;  // empty cache.
      lru_q   <= '0;  // way 0 fills first.
    end else begin
      state_q <= state_d;
      if (refill_done) begin
        valid_q[victim][idx] <= 1'b1;
      end
      if (hit) begin
        lru_q[idx] <= ~hit1; // other way becomes lru.
      end
    end
  end

  // address latch, taken when a fetch starts.
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && cpu_bus.valid) begin
      addr_q <= cpu_bus.req.addr;
    end
  end

  // line write on refill.
  always_ff @(posedge clk) begin
    if (refill_done) begin
      tag_q[victim][idx]  <= tag;
      data_q[victim][idx] <= ram_bus.rdata;
    end
  end

endmodule

`default_nettype wire

/* logic/mem_port.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// registered external memory port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module mem_port (
  input  logic            clk,
  input  logic            rst_n_i,
  mem_bus_if.responder    up_bus,      // from the router.
  output mem_pkg::word_t  mem_addr_o,
  output mem_pkg::word_t  mem_din_o,
  output mem_pkg::wmask_t mem_wmask_o,
  output logic            mem_valid_o,
  input  mem_pkg::word_t  mem_dout_i,
  input  logic            mem_ready_i
);
  import mem_pkg::*;

  typedef enum logic {
    IDLE, // no access on the memory side.
    BUSY  // request held until mem_ready_i.
  } state_e;

  state_e state_q;
  state_e state_d;

  logic  ack_q;   // upstream ready, one cycle.
  word_t rdata_q; // returned read data.
  logic  start;
  logic  done;

  // ack_q blocks a restart while the requester still holds valid.
  assign start = (state_q == IDLE) && up_bus.valid && !ack_q;
  assign done  = (state_q == BUSY) && mem_ready_i;

  always_comb begin
    state_d = state_q;
    if (start) state_d = BUSY;
    if (done)  state_d = IDLE;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= done;  // ready 1 cycle after mem_ready_i.
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mem_addr_o  <= up_bus.req.addr;
      mem_din_o   <= up_bus.req.wdata;
      mem_wmask_o <= up_bus.req.wmask;
    end
    if (done) begin
      rdata_q <= mem_dout_i;
    end
  end

  assign mem_valid_o   = (state_q == BUSY); // holds under back-pressure.
  assign up_bus.rdata  = rdata_q;
  assign up_bus.ready  = ack_q;

endmodule

`default_nettype wire

/* logic/cache_subsys.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu memory subsystem top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

`include "cache_params.svh"

module cache_subsys #(
  parameter int ICACHE_ENTRIES_PER_WAY = `ICACHE_ENTRIES_PER_WAY
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            is_instruction_i, // marks fetches.
  input  mem_pkg::word_t  cpu_addr_i,
  input  mem_pkg::word_t  cpu_din_i,
  input  mem_pkg::wmask_t cpu_wmask_i,
  input  logic            cpu_valid_i,
  output mem_pkg::word_t  cpu_dout_o,
  output logic            cpu_ready_o,
  output mem_pkg::word_t  mem_addr_o,
  output mem_pkg::word_t  mem_din_o,
  output mem_pkg::wmask_t mem_wmask_o,
  output logic            mem_valid_o,
  input  mem_pkg::word_t  mem_dout_i,
  input  logic            mem_ready_i
);

  mem_bus_if ic_cpu_bus ();   // router to icache.
  mem_bus_if ic_mem_bus ();   // icache refills.
  mem_bus_if mem_port_bus (); // shared path to memory.

  cache_router i_cache_router (
    .clk              (clk),
    .is_instruction_i (is_instruction_i),
    .cpu_addr_i       (cpu_addr_i),
    .cpu_din_i        (cpu_din_i),
    .cpu_wmask_i      (cpu_wmask_i),
    .cpu_valid_i      (cpu_valid_i),
    .cpu_dout_o       (cpu_dout_o),
    .cpu_ready_o      (cpu_ready_o),
    .ic_bus           (ic_cpu_bus.requester),
    .refill_bus       (ic_mem_bus.responder),
    .mem_bus          (mem_port_bus.requester)
  );

  icache #(
    .ENTRIES_PER_WAY (ICACHE_ENTRIES_PER_WAY)
  ) i_icache (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cpu_bus (ic_cpu_bus.responder),
    .ram_bus (ic_mem_bus.requester)
  );

  mem_port i_mem_port (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .up_bus      (mem_port_bus.responder),
    .mem_addr_o  (mem_addr_o),
    .mem_din_o   (mem_din_o),
    .mem_wmask_o (mem_wmask_o),
    .mem_valid_o (mem_valid_o),
    .mem_dout_i  (mem_dout_i),
    .mem_ready_i (mem_ready_i)
  );

endmodule

`default_nettype wire

/* testbench/tb_cache_subsys.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module tb_cache_subsys;
  import mem_pkg::*;

  localparam int SETS        = 4;  // small cache, easy set conflicts.
  localparam int HALF_CLK    = 4;  // 8 ns period.
  localparam int NUM_XACT    = 54; // cpu accesses over all tests.
  localparam int XACT_CYCLES = 20; // budget per access.

  logic   clk;
  logic   rst_n_i;
  logic   is_instruction_i;
  word_t  cpu_addr_i;
  word_t  cpu_din_i;
  wmask_t cpu_wmask_i;
  logic   cpu_valid_i;
  word_t  cpu_dout_o;
  logic   cpu_ready_o;
  word_t  mem_addr_o;
  word_t  mem_din_o;
  wmask_t mem_wmask_o;
  logic   mem_valid_o;
  word_t  mem_dout_i;
  logic   mem_ready_i;

  int     xact_cnt;   // completed memory transactions.
  int     fail_cnt;
  word_t  last_addr;  // last request seen by memory.
  word_t  last_wdata;
  wmask_t last_wmask;

  word_t  mem_q [word_t]; // sparse memory, keyed by word index.

  // reference icache state, tags hold the word index.
  word_t  ref_tag  [2][SETS];
  word_t  ref_data [2][SETS];
  logic   ref_valid[2][SETS];
  logic   ref_lru  [SETS]; // least recently used way.

  cache_subsys #(
    .ICACHE_ENTRIES_PER_WAY (SETS)
  ) i_cache_subsys (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .is_instruction_i (is_instruction_i),
    .cpu_addr_i       (cpu_addr_i),
    .cpu_din_i        (cpu_din_i),
    .cpu_wmask_i      (cpu_wmask_i),
    .cpu_valid_i      (cpu_valid_i),
    .cpu_dout_o       (cpu_dout_o),
    .cpu_ready_o      (cpu_ready_o),
    .mem_addr_o       (mem_addr_o),
    .mem_din_o        (mem_din_o),
    .mem_wmask_o      (mem_wmask_o),
    .mem_valid_o      (mem_valid_o),
    .mem_dout_i       (mem_dout_i),
    .mem_ready_i      (mem_ready_i)
  );

  initial clk = 1'b0;
  always #HALF_CLK clk = ~clk;

  // untouched words, scrambled over the whole address.
  function automatic word_t fill_word(input word_t addr);
    return (addr * 32'h9E37_79B9) ^ 32'hC0DE_5A5A;
  endfunction

  function automatic word_t mem_read(input word_t addr);
    if (mem_q.exists(addr[31:2])) return mem_q[addr[31:2]];
    return fill_word({addr[31:2], 2'b00});
  endfunction

  task automatic check_eq(input word_t got, input word_t exp, input string msg);
    if (got !== exp) begin
      fail_cnt++;
      $display("** Error @ %0d ns: %s, got %h expected %h", $time, msg, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  // memory side, random 0..3 cycle answer delay.
  initial begin : memory_model
    int    delay;
    word_t merged;
    mem_ready_i = 1'b0;
    mem_dout_i  = '0;
    xact_cnt    = 0;
    forever begin
      @(negedge clk);
      if (mem_valid_o) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk); // request must hold meanwhile.
        last_addr  = mem_addr_o;
        last_wdata = mem_din_o;
        last_wmask = mem_wmask_o;
        merged     = mem_read(mem_addr_o);
        for (int b = 0; b < 4; b++) begin
          if (mem_wmask_o[b]) merged[8*b +: 8] = mem_din_o[8*b +: 8];
        end
        if (mem_wmask_o != '0) mem_q[mem_addr_o[31:2]] = merged;
        mem_dout_i  = merged;
        mem_ready_i = 1'b1;
        xact_cnt++;
        @(negedge clk);
        mem_ready_i = 1'b0;
      end
    end
  end

  // one cpu request, called and left on a falling edge.
  task automatic cpu_access(input logic instr, input word_t addr, input word_t wdata,
                            input wmask_t wmask, output word_t rdata, output int cycles,
                            output int xacts);
    int start_cnt;
    start_cnt        = xact_cnt;
    is_instruction_i = instr;
    cpu_addr_i       = addr;
    cpu_din_i        = wdata;
    cpu_wmask_i      = wmask;
    cpu_valid_i      = 1'b1;
    cycles           = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!cpu_ready_o);
    rdata = cpu_dout_o;
    @(negedge clk); // handshake taken on the edge in between.
    cpu_valid_i = 1'b0;
    xacts       = xact_cnt - start_cnt;
  endtask

  // 2-way lru model, fills the lru way on a miss.
  task automatic ref_lookup(input word_t addr, output word_t data, output logic hit);
    int set;
    int way;
    set = (addr >> 2) % SETS;
    way = ref_lru[set];
    hit = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (ref_valid[w][set] && ref_tag[w][set] == (addr >> 2)) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      ref_valid[way][set] = 1'b1;
      ref_tag[way][set]   = addr >> 2;
      ref_data[way][set]  = mem_read(addr);
    end
    data         = ref_data[way][set];
    ref_lru[set] = (way == 0); // other way now lru.
  endtask

  task automatic fetch_checked(input word_t addr, input string what, output word_t got,
                               output logic was_hit);
    word_t exp_data;
    logic  exp_hit;
    int    cycles;
    int    xacts;
    ref_lookup(addr, exp_data, exp_hit);
    cpu_access(1'b1, addr, '0, '0, got, cycles, xacts);
    was_hit = (xacts == 0); // no memory access seen.
    check_eq(got, exp_data, {what, " data"});
    check_eq(xacts, exp_hit ? 0 : 1, {what, " memory transactions"});
    if (exp_hit) check_eq(cycles, 1, {what, " hit latency"});
  endtask

  task automatic reset_and_cold_fetch();
    word_t got;
    logic  hit;
    check_eq(cpu_ready_o, 1'b0, "cpu_ready_o after reset");
    check_eq(mem_valid_o, 1'b0, "mem_valid_o after reset");
    fetch_checked(32'h0000_0204, "cold fetch", got, hit);
    check_eq(hit, 1'b0, "cold fetch miss");
    check_eq(got, fill_word(32'h0000_0204), "cold fetch word");
  endtask

  task automatic repeat_fetch_hits();
    word_t got;
    logic  hit;
    fetch_checked(32'h0000_0204, "repeat fetch", got, hit);
    check_eq(hit, 1'b1, "repeat fetch hit");
    check_eq(got, fill_word(32'h0000_0204), "repeat fetch word");
  endtask

  task automatic data_bypasses_cache();
    word_t addr;
    word_t f;
    word_t got;
    int    cycles;
    int    xacts;
    logic  hit;
    addr = 32'h0000_040C;
    f    = fill_word(addr);
    cpu_access(1'b0, addr, 32'hDEAD_BEEF, 4'b0110, got, cycles, xacts);
    check_eq(xacts, 1, "store transactions");
    check_eq(last_addr, addr, "store address");
    check_eq(last_wdata, 32'hDEAD_BEEF, "store data");
    check_eq(last_wmask, 4'b0110, "store mask");
    cpu_access(1'b0, addr, '0, '0, got, cycles, xacts);
    check_eq(xacts, 1, "load transactions");
    check_eq(last_wmask, 4'b0000, "load mask");
    check_eq(got, {f[31:24], 8'hAD, 8'hBE, f[7:0]}, "load merged bytes");
    // a later fetch still misses, so neither access filled a line.
    fetch_checked(addr, "fetch after data access", got, hit);
    check_eq(hit, 1'b0, "fetch after data access miss");
  endtask

  task automatic lru_replacement();
    word_t got;
    logic  hit;
    fetch_checked(32'h0000_0100, "lru fetch a", got, hit);
    fetch_checked(32'h0000_0110, "lru fetch b", got, hit);
    fetch_checked(32'h0000_0100, "lru fetch a again", got, hit);
    check_eq(hit, 1'b1, "a hits before c");
    fetch_checked(32'h0000_0120, "lru fetch c", got, hit);
    check_eq(hit, 1'b0, "c misses");
    fetch_checked(32'h0000_0100, "lru fetch a after c", got, hit);
    check_eq(hit, 1'b1, "a survives c");
    fetch_checked(32'h0000_0110, "lru fetch b after c", got, hit);
    check_eq(hit, 1'b0, "b evicted by c");
  endtask

  task automatic stale_fetch_after_store();
    word_t addr;
    word_t got;
    int    cycles;
    int    xacts;
    logic  hit;
    addr = 32'h0000_0308;
    fetch_checked(addr, "fetch x", got, hit);
    cpu_access(1'b0, addr, 32'h1234_5678, 4'b1111, got, cycles, xacts);
    check_eq(xacts, 1, "store to x transactions");
    fetch_checked(addr, "fetch x after store", got, hit);
    check_eq(hit, 1'b1, "fetch x after store hit");
    check_eq(got, fill_word(addr), "fetch x returns old word");
  endtask

  task automatic random_fetches();
    word_t got;
    logic  hit;
    for (int i = 0; i < 40; i++) begin
      fetch_checked(32'h0000_1000 + 4 * $urandom_range(15, 0), "random fetch", got, hit);
    end
  endtask

  initial begin : watchdog
    #((NUM_XACT * XACT_CYCLES + 2) * 2 * HALF_CLK);
    $display("watchdog expired, a cpu access never completed");
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(98));
    fail_cnt         = 0;
    rst_n_i          = 1'b0;
    is_instruction_i = 1'b0;
    cpu_addr_i       = '0;
    cpu_din_i        = '0;
    cpu_wmask_i      = '0;
    cpu_valid_i      = 1'b0;
    foreach (ref_valid[w, s]) ref_valid[w][s] = 1'b0;
    foreach (ref_lru[s]) ref_lru[s] = 1'b0;
    repeat (2) @(negedge clk);
    rst_n_i = 1'b1;
    reset_and_cold_fetch();
    repeat_fetch_hits();
    data_bypasses_cache();
    lru_replacement();
    stale_fetch_after_store();
    random_fetches();
    if (fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/mem_pkg.sv
logic/mem_bus_if.sv
logic/cache_router.sv
logic/icache.sv
logic/mem_port.sv
logic/cache_subsys.sv
testbench/tb_cache_subsys.sv

/* Bender.yml */
package:
  name: cache_subsys

export_include_dirs:
  - logic

sources:
  - files:
      - logic/mem_pkg.sv
      - logic/mem_bus_if.sv
      - logic/cache_router.sv
      - logic/icache.sv
      - logic/mem_port.sv
      - logic/cache_subsys.sv
  - target: test
    files:
      - testbench/tb_cache_subsys.sv
